// File: common/bus_msg_pkg.sv
//********************
// bus message package
// message encodings of the shared bus and the request
// classes that the L1 bus interface recognises
//********************
package bus_msg_pkg;

    localparam int msg_bits = 4;

    // encodings 4, 5, 9, 11, 13, 14 and 15 are reserved
    typedef enum logic [msg_bits-1:0] {
        NO_REQ     = 4'd0,
        R_REQ      = 4'd1,
        WB_REQ     = 4'd2,
        FLUSH      = 4'd3,
        RFO_BCAST  = 4'd6,
        C_WB       = 4'd7,
        C_FLUSH    = 4'd8,
        MEM_RESP   = 4'd10,
        MEM_C_RESP = 4'd12
    } bus_msg_t;

    // cache requests that bring a line back from memory
    function automatic logic is_cache_read(bus_msg_t msg);
        return (msg == R_REQ) || (msg == RFO_BCAST);
    endfunction

    // cache requests that push a line out to memory
    function automatic logic is_cache_write(bus_msg_t msg);
        return (msg == WB_REQ) || (msg == FLUSH);
    endfunction

    // snooper writebacks, answered with MEM_C_RESP
    function automatic logic is_snoop_write(bus_msg_t msg);
        return (msg == C_WB) || (msg == C_FLUSH);
    endfunction

endpackage

// File: dv/memory_bus_model.sv
`timescale 1ns/1ps
//********************
// memory bus model
// answers bus requests like memory, with random grant and
// response delays, and keeps written lines by address
//********************
module memory_bus_model
    import bus_msg_pkg::*;
#(
    parameter int          data_width    = 32,
    parameter int          address_width = 32,
    parameter int          line_words    = 4,
    parameter int          bus_words     = 2,
    parameter logic [31:0] seed          = 32'd72438
) (
    input  logic                             clock,
    input  logic                             reset,
    input  bus_msg_t                         bus_msg_out,
    input  logic [address_width-1:0]         bus_address_out,
    input  logic [bus_words*data_width-1:0]  bus_data_out,
    output bus_msg_t                         bus_msg_in,
    output logic [bus_words*data_width-1:0]  bus_data_in,
    output logic                             bus_master
);

    localparam int line_beats = line_words / bus_words;
    localparam int beat_width = bus_words * data_width;
    localparam int line_width = line_words * data_width;

    logic [line_width-1:0] store [logic [address_width-1:0]];
    logic [31:0]           rng = seed;

    function automatic int random_below(input int span);
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return int'(rng % span);
    endfunction

    // contents of a line that was never written
    function automatic logic [line_width-1:0] unwritten_line(input logic [address_width-1:0] a);
        logic [line_width-1:0] l;
        for (int i = 0; i < line_words; i++) begin
            l[i*data_width +: data_width] = data_width'(a * 32'h9e37_79b9 + i);
        end
        return l;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #0.5;
    endtask

    task automatic serve();
        bus_msg_t                 msg;
        logic [address_width-1:0] addr;
        logic [line_width-1:0]    data;
        logic                     writes;
        msg    = bus_msg_out;
        addr   = bus_address_out;
        writes = msg inside {WB_REQ, FLUSH, C_WB, C_FLUSH};
        if (writes) begin
            repeat (random_below(6)) next_cycle();
            bus_master = 1'b1;
            next_cycle();                           // edge that samples the grant
            for (int k = 0; k < line_beats; k++) begin
                next_cycle();
                data[k*beat_width +: beat_width] = bus_data_out;
            end
            bus_master = 1'b0;
            store[addr] = data;
        end else begin
            data = store.exists(addr) ? store[addr] : unwritten_line(addr);
        end
        repeat (1 + random_below(6)) next_cycle();
        if (writes) begin
            bus_msg_in = (msg inside {C_WB, C_FLUSH}) ? MEM_C_RESP : MEM_RESP;
            next_cycle();
        end else begin
            bus_msg_in = MEM_RESP;                  // held across all read beats
            for (int k = 0; k < line_beats; k++) begin
                bus_data_in = data[k*beat_width +: beat_width];
                next_cycle();
            end
        end
        bus_msg_in  = NO_REQ;
        bus_data_in = '0;
    endtask

    initial begin
        bus_msg_in  = NO_REQ;
        bus_data_in = '0;
        bus_master  = 1'b0;
        forever begin
            next_cycle();
            if (!reset && bus_msg_out != NO_REQ) begin
                serve();
            end
        end
    end

endmodule

// File: dv/tb_l1_bus_interface.sv
`timescale 1ns/1ps
//********************
// L1 bus interface testbench
// random cache and snooper requests against a memory model,
// checked against a reference line store
//********************
module tb_l1_bus_interface
    import bus_msg_pkg::*;
();

    localparam int data_width       = 32;
    localparam int address_width    = 32;
    localparam int line_words       = 4;
    localparam int bus_words        = 2;
    localparam int line_beats       = line_words / bus_words;
    localparam int beat_width       = bus_words * data_width;
    localparam int line_width       = line_words * data_width;
    localparam int num_transactions = 200;
    localparam int cycle_limit      = num_transactions * 40 + 8;

    logic                     clock = 1'b0;
    logic                     reset = 1'b1;
    bus_msg_t                 cache_msg_in;
    logic [address_width-1:0] cache_address_in;
    logic [line_width-1:0]    cache_data_in;
    bus_msg_t                 cache_msg_out;
    logic [address_width-1:0] cache_address_out;
    logic [line_width-1:0]    cache_data_out;
    bus_msg_t                 snoop_msg_in;
    logic [address_width-1:0] snoop_address_in;
    logic [line_width-1:0]    snoop_data_in;
    bus_msg_t                 snoop_msg_out;
    logic [address_width-1:0] snoop_address_out;
    bus_msg_t                 bus_msg_in;
    logic [beat_width-1:0]    bus_data_in;
    logic                     bus_master;
    bus_msg_t                 bus_msg_out;
    logic [address_width-1:0] bus_address_out;
    logic [beat_width-1:0]    bus_data_out;

    logic [31:0]           rng = 32'd72438;
    logic [line_width-1:0] ref_store [logic [address_width-1:0]];  // reference memory
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    cycles = 0;

    // beat monitor state
    logic     in_txn = 1'b0;
    logic     txn_writes = 1'b0;
    logic     granted = 1'b0;
    int       beat_count = 0;
    logic [line_width-1:0] source_line;

    l1_bus_interface #(
        .data_width    (data_width),
        .address_width (address_width),
        .line_words    (line_words),
        .bus_words     (bus_words)
    ) i_dut (
        .clock             (clock),
        .reset             (reset),
        .cache_msg_in      (cache_msg_in),
        .cache_address_in  (cache_address_in),
        .cache_data_in     (cache_data_in),
        .cache_msg_out     (cache_msg_out),
        .cache_address_out (cache_address_out),
        .cache_data_out    (cache_data_out),
        .snoop_msg_in      (snoop_msg_in),
        .snoop_address_in  (snoop_address_in),
        .snoop_data_in     (snoop_data_in),
        .snoop_msg_out     (snoop_msg_out),
        .snoop_address_out (snoop_address_out),
        .bus_msg_in        (bus_msg_in),
        .bus_data_in       (bus_data_in),
        .bus_master        (bus_master),
        .bus_msg_out       (bus_msg_out),
        .bus_address_out   (bus_address_out),
        .bus_data_out      (bus_data_out)
    );

    memory_bus_model #(
        .data_width    (data_width),
        .address_width (address_width),
        .line_words    (line_words),
        .bus_words     (bus_words),
        .seed          (32'd72438)
    ) i_memory (
        .clock           (clock),
        .reset           (reset),
        .bus_msg_out     (bus_msg_out),
        .bus_address_out (bus_address_out),
        .bus_data_out    (bus_data_out),
        .bus_msg_in      (bus_msg_in),
        .bus_data_in     (bus_data_in),
        .bus_master      (bus_master)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int random_below(input int span);
        return int'(next_random() % span);
    endfunction

    function automatic logic [line_width-1:0] random_line();
        logic [line_width-1:0] l;
        for (int i = 0; i < line_words; i++) begin
            l[i*data_width +: data_width] = next_random();   // never zero
        end
        return l;
    endfunction

    // memory contents before the first write to a line
    function automatic logic [line_width-1:0] initial_line(input logic [address_width-1:0] a);
        logic [line_width-1:0] l;
        for (int i = 0; i < line_words; i++) begin
            l[i*data_width +: data_width] = data_width'(a * 32'h9e37_79b9 + i);
        end
        return l;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #0.5;                           // outputs settled, inputs driven here
    endtask

    task automatic value_mismatch(input string name, input logic [line_width-1:0] got,
                                  input logic [line_width-1:0] expected);
        $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, expected);
        value_errors++;
    endtask

    task automatic protocol_failure(input string text);
        $display("Failure at %0t: %s", $time, text);
        other_errors++;
    endtask

    task automatic print_counts();
        $display("value errors: %0d, other failures: %0d", value_errors, other_errors);
    endtask

    // follow one request from acceptance to its response pulse, then drop it
    task automatic run_request(input logic from_snoop, input bus_msg_t msg,
                               input logic [address_width-1:0] addr,
                               input logic [line_width-1:0] data);
        logic                  pulse;
        logic                  writes;
        logic [line_width-1:0] expected;
        writes = from_snoop || msg == WB_REQ || msg == FLUSH;
        do begin
            next_cycle();
            assert (cache_msg_out == NO_REQ && snoop_msg_out == NO_REQ)
            else protocol_failure("response output active outside a response pulse");
        end while (bus_msg_out == NO_REQ);
        assert (bus_msg_out == msg) else value_mismatch("bus_msg_out", bus_msg_out, msg);
        assert (bus_address_out == addr)
        else value_mismatch("bus_address_out", bus_address_out, addr);
        do begin
            next_cycle();
            pulse = from_snoop ? (snoop_msg_out != NO_REQ) : (cache_msg_out != NO_REQ);
            assert ((from_snoop ? cache_msg_out : snoop_msg_out) == NO_REQ)
            else protocol_failure("response went to the wrong requester");
            if (!pulse) begin
                assert (bus_msg_out == msg) else value_mismatch("bus_msg_out", bus_msg_out, msg);
            end
        end while (!pulse);
        assert (bus_msg_out == NO_REQ) else value_mismatch("bus_msg_out", bus_msg_out, NO_REQ);
        if (from_snoop) begin
            assert (snoop_msg_out == MEM_RESP)
            else value_mismatch("snoop_msg_out", snoop_msg_out, MEM_RESP);
            assert (snoop_address_out == addr)
            else value_mismatch("snoop_address_out", snoop_address_out, addr);
            ref_store[addr] = data;
            snoop_msg_in = NO_REQ;
        end else begin
            if (writes) begin
                expected = '0;
            end else begin
                expected = ref_store.exists(addr) ? ref_store[addr] : initial_line(addr);
            end
            assert (cache_msg_out == MEM_RESP)
            else value_mismatch("cache_msg_out", cache_msg_out, MEM_RESP);
            assert (cache_address_out == addr)
            else value_mismatch("cache_address_out", cache_address_out, addr);
            assert (cache_data_out == expected)
            else value_mismatch("cache_data_out", cache_data_out, expected);
            if (writes) begin
                ref_store[addr] = data;
            end
            cache_msg_in = NO_REQ;
        end
    endtask

    // write beats, watched mid-cycle where bus and grant are stable
    always @(negedge clock) begin
        if (reset || bus_msg_out == NO_REQ) begin
            if (in_txn) begin
                assert (beat_count == (txn_writes ? line_beats : 0))
                else protocol_failure($sformatf("%0d data beats seen in one transaction",
                                                beat_count));
            end
            in_txn     = 1'b0;
            granted    = 1'b0;
            beat_count = 0;
        end else begin
            in_txn      = 1'b1;
            txn_writes  = bus_msg_out inside {WB_REQ, FLUSH, C_WB, C_FLUSH};
            source_line = (bus_msg_out inside {C_WB, C_FLUSH}) ? snoop_data_in : cache_data_in;
            if (bus_data_out != '0) begin
                assert (granted) else protocol_failure("data beat before bus_master grant");
                if (beat_count < line_beats) begin
                    assert (bus_data_out == source_line[beat_count*beat_width +: beat_width])
                    else value_mismatch("bus_data_out", bus_data_out,
                                        source_line[beat_count*beat_width +: beat_width]);
                end
                beat_count++;
            end
            if (bus_master) begin
                granted = 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run not finished after %0d cycles", cycle_limit);
            print_counts();
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int                       pick;
        logic                     use_cache;
        logic                     use_snoop;
        bus_msg_t                 cmsg;
        bus_msg_t                 smsg;
        logic [address_width-1:0] caddr;
        logic [address_width-1:0] saddr;
        logic [line_width-1:0]    cline;
        logic [line_width-1:0]    sline;
        cache_msg_in     = NO_REQ;
        cache_address_in = '0;
        cache_data_in    = '0;
        snoop_msg_in     = NO_REQ;
        snoop_address_in = '0;
        snoop_data_in    = '0;
        repeat (8) @(posedge clock);
        #0.5 reset = 1'b0;
        for (int n = 0; n < num_transactions; n++) begin
            pick      = random_below(4);
            use_snoop = (pick < 2);
            use_cache = (pick != 1);        // pick 0 is a tie
            smsg      = random_below(2) ? C_FLUSH : C_WB;
            case (random_below(4))
                0:       cmsg = R_REQ;
                1:       cmsg = RFO_BCAST;
                2:       cmsg = WB_REQ;
                default: cmsg = FLUSH;
            endcase
            caddr = 32'h1000 + random_below(6) * 32'h10;   // small pool so reads hit writes
            saddr = 32'h1000 + random_below(6) * 32'h10;
            cline = random_line();
            sline = random_line();
            if (use_snoop) begin
                snoop_msg_in     = smsg;
                snoop_address_in = saddr;
                snoop_data_in    = sline;
            end
            if (use_cache) begin
                cache_msg_in     = cmsg;
                cache_address_in = caddr;
                cache_data_in    = cline;
            end
            if (use_snoop) begin
                run_request(1'b1, smsg, saddr, sline);
            end
            if (use_cache) begin
                run_request(1'b0, cmsg, caddr, cline);
            end
        end
        repeat (2) next_cycle();
        print_counts();
        if (value_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: hdl/beat_collector.sv
`timescale 1ns/1ps
//********************
// beat collector
// waits for the memory response, assembles read beats into a line
// and returns a one-cycle response to the requester
//********************
module beat_collector
    import bus_msg_pkg::*;
#(
    parameter int data_width    = 32,
    parameter int address_width = 32,
    parameter int line_words    = 4,
    parameter int bus_words     = 2
) (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic                                            start,
    input  logic                                            sent,
    input  logic [address_width+line_words*data_width-1:0]  line,
    input  logic                                            is_write,
    input  logic                                            to_snooper,
    input  bus_msg_t                                        bus_msg_in,
    input  logic [bus_words*data_width-1:0]                 bus_data_in,
    output logic                                            done,
    output bus_msg_t                                        cache_msg_out,
    output logic [address_width-1:0]                        cache_address_out,
    output logic [line_words*data_width-1:0]                cache_data_out,
    output bus_msg_t                                        snoop_msg_out,
    output logic [address_width-1:0]                        snoop_address_out
);

    localparam int line_beats = line_words / bus_words;
    localparam int beat_width = bus_words * data_width;
    localparam int line_width = line_words * data_width;
    localparam int cnt_bits   = (line_beats > 1) ? $clog2(line_beats) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SENT,    // write beats still going out
        ST_RESP,
        ST_GATHER   // remaining read beats
    } col_state_t;

    col_state_t                state;
    logic [cnt_bits-1:0]       beat_cnt;
    logic [address_width-1:0]  address_q;
    logic [line_width-1:0]     line_buf;
    logic [line_width-1:0]     line_next;   // buffer with the current beat merged in
    bus_msg_t                  resp_msg;
    logic                      resp_ok;
    logic                      capture;

    // is_write and to_snooper stay stable in the arbiter until done
    assign resp_msg = to_snooper ? MEM_C_RESP : MEM_RESP;
    assign resp_ok  = (state == ST_RESP) && (bus_msg_in == resp_msg);
    assign capture  = (resp_ok && !is_write) || (state == ST_GATHER);

    always_comb begin
        line_next = line_buf;
        if (capture) begin
            line_next[beat_cnt*beat_width +: beat_width] = bus_data_in;
        end
    end

    assign done = (resp_ok && (is_write || line_beats == 1)) ||
                  ((state == ST_GATHER) && (beat_cnt == cnt_bits'(line_beats - 1)));

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        beat_cnt <= '0;
                        state    <= sent ? ST_RESP : ST_SENT;   // reads skip straight on
                    end
                end
                ST_SENT: begin
                    if (sent) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end else if (resp_ok) begin
                        beat_cnt <= beat_cnt + 1'b1;        // beat 0 came with the response
                        state    <= ST_GATHER;
                    end
                end
                ST_GATHER: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            address_q <= line[line_width +: address_width];
        end
        if (capture) begin
            line_buf <= line_next;
        end
    end

    // response pulse, one cycle wide, to whoever owns the transaction
    always_ff @(posedge clock) begin
        if (reset) begin
            cache_msg_out     <= NO_REQ;
            cache_address_out <= '0;
            cache_data_out    <= '0;
            snoop_msg_out     <= NO_REQ;
            snoop_address_out <= '0;
        end else begin
            cache_msg_out     <= NO_REQ;
            cache_address_out <= '0;
            cache_data_out    <= '0;
            snoop_msg_out     <= NO_REQ;
            snoop_address_out <= '0;
            if (done && to_snooper) begin
                snoop_msg_out     <= MEM_RESP;
                snoop_address_out <= address_q;
            end else if (done) begin
                cache_msg_out     <= bus_msg_in;
                cache_address_out <= address_q;
                cache_data_out    <= is_write ? '0 : line_next;
            end
        end
    end

    // the arbiter releases on done, so two in a row would drop a request
    a_done_pulse: assert property (@(posedge clock) disable iff (reset)
        done |=> !done);

endmodule

// File: hdl/beat_serializer.sv
`timescale 1ns/1ps
//********************
// beat serializer
// waits for the bus grant and sends a captured line as
// consecutive data beats, lowest words first
//********************
module beat_serializer #(
    parameter int data_width    = 32,
    parameter int address_width = 32,
    parameter int line_words    = 4,
    parameter int bus_words     = 2
) (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic                                            start,
    input  logic [address_width+line_words*data_width-1:0]  line,
    input  logic                                            is_write,
    input  logic                                            bus_master,
    output logic [bus_words*data_width-1:0]                 bus_data_out,
    output logic                                            sent
);

    localparam int line_beats = line_words / bus_words;
    localparam int beat_width = bus_words * data_width;
    localparam int cnt_bits   = $clog2(line_beats + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_GRANT,    // write pending, bus not yet granted
        S_SEND
    } ser_state_t;

    ser_state_t                      state;
    logic [cnt_bits-1:0]             beat_cnt;     // beats already on the bus
    logic                            last_beat;
    logic [line_words*data_width-1:0] words;

    assign words = line[line_words*data_width-1:0];  // address bits are not sent

    // reads carry no data, so they are reported sent right away
    assign sent = last_beat || (start && !is_write);

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= S_IDLE;
            beat_cnt     <= '0;
            last_beat    <= 1'b0;
            bus_data_out <= '0;
        end else begin
            last_beat <= 1'b0;
            case (state)
                S_IDLE: begin
                    beat_cnt <= '0;
                    if (start && is_write) begin
                        state <= bus_master ? S_SEND : S_GRANT;
                    end
                end
                S_GRANT: begin
                    if (bus_master) begin
                        state <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (beat_cnt == cnt_bits'(line_beats)) begin
                        bus_data_out <= '0;        // bus idles at zero between beats
                        state        <= S_IDLE;
                    end else begin
                        bus_data_out <= words[beat_cnt*beat_width +: beat_width];
                        beat_cnt     <= beat_cnt + 1'b1;
                        last_beat    <= (beat_cnt == cnt_bits'(line_beats - 1));
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_beat_bound: assert property (@(posedge clock) disable iff (reset)
        beat_cnt <= cnt_bits'(line_beats));

endmodule

// File: hdl/l1_bus_interface.sv
`timescale 1ns/1ps
//********************
// L1 bus interface
// connects one L1 cache and its snooper to the shared bus,
// one transaction at a time: arbiter, serializer, collector
//********************
module l1_bus_interface
    import bus_msg_pkg::*;
#(
    parameter int data_width    = 32,
    parameter int address_width = 32,
    parameter int line_words    = 4,
    parameter int bus_words     = 2
) (
    input  logic                                clock,
    input  logic                                reset,

    input  bus_msg_t                            cache_msg_in,
    input  logic [address_width-1:0]            cache_address_in,
    input  logic [line_words*data_width-1:0]    cache_data_in,
    output bus_msg_t                            cache_msg_out,
    output logic [address_width-1:0]            cache_address_out,
    output logic [line_words*data_width-1:0]    cache_data_out,

    input  bus_msg_t                            snoop_msg_in,
    input  logic [address_width-1:0]            snoop_address_in,
    input  logic [line_words*data_width-1:0]    snoop_data_in,
    output bus_msg_t                            snoop_msg_out,
    output logic [address_width-1:0]            snoop_address_out,

    input  bus_msg_t                            bus_msg_in,
    input  logic [bus_words*data_width-1:0]     bus_data_in,
    input  logic                                bus_master,
    output bus_msg_t                            bus_msg_out,
    output logic [address_width-1:0]            bus_address_out,
    output logic [bus_words*data_width-1:0]     bus_data_out
);

    localparam int bundle_width = address_width + line_words * data_width;

    logic                    start;       // one cycle after acceptance
    logic [bundle_width-1:0] line;        // address on top, words below
    logic                    is_write;
    logic                    to_snooper;
    logic                    sent;
    logic                    done;

    request_arbiter #(
        .data_width    (data_width),
        .address_width (address_width),
        .line_words    (line_words)
    ) i_request_arbiter (
        .clock            (clock),
        .reset            (reset),
        .cache_msg_in     (cache_msg_in),
        .cache_address_in (cache_address_in),
        .cache_data_in    (cache_data_in),
        .snoop_msg_in     (snoop_msg_in),
        .snoop_address_in (snoop_address_in),
        .snoop_data_in    (snoop_data_in),
        .done             (done),
        .start            (start),
        .line             (line),
        .is_write         (is_write),
        .to_snooper       (to_snooper),
        .bus_msg_out      (bus_msg_out),
        .bus_address_out  (bus_address_out)
    );

    beat_serializer #(
        .data_width    (data_width),
        .address_width (address_width),
        .line_words    (line_words),
        .bus_words     (bus_words)
    ) i_beat_serializer (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .line         (line),
        .is_write     (is_write),
        .bus_master   (bus_master),
        .bus_data_out (bus_data_out),
        .sent         (sent)
    );

    beat_collector #(
        .data_width    (data_width),
        .address_width (address_width),
        .line_words    (line_words),
        .bus_words     (bus_words)
    ) i_beat_collector (
        .clock             (clock),
        .reset             (reset),
        .start             (start),
        .sent              (sent),
        .line              (line),
        .is_write          (is_write),
        .to_snooper        (to_snooper),
        .bus_msg_in        (bus_msg_in),
        .bus_data_in       (bus_data_in),
        .done              (done),
        .cache_msg_out     (cache_msg_out),
        .cache_address_out (cache_address_out),
        .cache_data_out    (cache_data_out),
        .snoop_msg_out     (snoop_msg_out),
        .snoop_address_out (snoop_address_out)
    );

endmodule

// File: hdl/request_arbiter.sv
`timescale 1ns/1ps
//********************
// request arbiter
// accepts one cache or snooper request while idle, snooper first,
// and drives the bus message and address until the transaction ends
//********************
module request_arbiter
    import bus_msg_pkg::*;
#(
    parameter int data_width    = 32,
    parameter int address_width = 32,
    parameter int line_words    = 4
) (
    input  logic                                            clock,
    input  logic                                            reset,

    input  bus_msg_t                                        cache_msg_in,
    input  logic [address_width-1:0]                        cache_address_in,
    input  logic [line_words*data_width-1:0]                cache_data_in,

    input  bus_msg_t                                        snoop_msg_in,
    input  logic [address_width-1:0]                        snoop_address_in,
    input  logic [line_words*data_width-1:0]                snoop_data_in,

    input  logic                                            done,

    output logic                                            start,
    output logic [address_width+line_words*data_width-1:0]  line,
    output logic                                            is_write,
    output logic                                            to_snooper,
    output bus_msg_t                                        bus_msg_out,
    output logic [address_width-1:0]                        bus_address_out
);

    logic busy;         // a transaction is on the bus
    logic cache_valid;
    logic snoop_valid;

    assign snoop_valid = is_snoop_write(snoop_msg_in);
    assign cache_valid = is_cache_read(cache_msg_in) || is_cache_write(cache_msg_in);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy            <= 1'b0;
            start           <= 1'b0;
            is_write        <= 1'b0;
            to_snooper      <= 1'b0;
            bus_msg_out     <= NO_REQ;
            bus_address_out <= '0;
        end else begin
            start <= 1'b0;
            if (!busy) begin
                if (snoop_valid) begin              // snooper wins a tie
                    busy            <= 1'b1;
                    start           <= 1'b1;
                    is_write        <= 1'b1;
                    to_snooper      <= 1'b1;
                    bus_msg_out     <= snoop_msg_in;
                    bus_address_out <= snoop_address_in;
                end else if (cache_valid) begin
                    busy            <= 1'b1;
                    start           <= 1'b1;
                    is_write        <= is_cache_write(cache_msg_in);
                    to_snooper      <= 1'b0;
                    bus_msg_out     <= cache_msg_in;
                    bus_address_out <= cache_address_in;
                end
            end else if (done) begin
                // release the bus at the edge of the response pulse
                busy            <= 1'b0;
                bus_msg_out     <= NO_REQ;
                bus_address_out <= '0;
            end
        end
    end

    // captured request, held stable for the serializer and collector
    always_ff @(posedge clock) begin
        if (!busy) begin
            if (snoop_valid) begin
                line <= {snoop_address_in, snoop_data_in};
            end else if (cache_valid) begin
                line <= {cache_address_in, cache_data_in};
            end
        end
    end

    // done may only close a transaction in flight, never one being started
    a_done_in_flight: assert property (@(posedge clock) disable iff (reset)
        done |-> busy && !start);

endmodule

// File: l1_bus_interface.f
common/bus_msg_pkg.sv
hdl/request_arbiter.sv
hdl/beat_serializer.sv
hdl/beat_collector.sv
hdl/l1_bus_interface.sv
dv/memory_bus_model.sv
dv/tb_l1_bus_interface.sv

// File: run_sim.sh
#!/bin/sh
# build and run the L1 bus interface testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l1_bus_interface \
    -f l1_bus_interface.f

./obj_dir/Vtb_l1_bus_interface | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
